/* Bender.yml */
package:
  name: snake

export_include_dirs:
  - .

sources:
  - files:
      - snake_pkg.sv
      - snake_ctrl.sv
      - direction_filter.sv
      - update_body.sv
      - collision_check.sv
      - apple_gen.sv
      - snake_core.sv
  - target: test
    files:
      - snake_clk_gen.sv
      - snake_assert.sv
      - snake_tb.sv

/* apple_gen.sv */
`timescale 1ns/1ps
`include "snake_defines.svh"

module apple_gen (
    input  logic       clk,
    input  logic       nrst,
    input  logic       sync,
    input  logic       eat,
    output logic [7:0] apple
);

    logic [7:0] lfsr;
    logic [7:0] lfsr_step;

    // ======================================================================
    // Galois LFSR, shifting right
    // ======================================================================

    assign lfsr_step = {1'b0, lfsr[7:1]} ^ (lfsr[0] ? `SNAKE_LFSR_TAPS : 8'h00);

    always_ff @(posedge clk or negedge nrst) begin
        if (!nrst) begin
            lfsr <= `SNAKE_LFSR_SEED;
        end else if (sync) begin
            lfsr <= `SNAKE_LFSR_SEED;   // Same apple sequence each game.
        end else if (eat) begin
            lfsr <= lfsr_step;
        end
    end

    // No check against the body cells.
    assign apple = lfsr;

endmodule

/* collision_check.sv */
`timescale 1ns/1ps
`include "snake_defines.svh"

module collision_check #(
    parameter int MAX_LENGTH = `SNAKE_MAX_LENGTH
) (
    input  logic [7:0]                 head,
    input  logic [MAX_LENGTH-1:0][7:0] body,
    input  logic [6:0]                 curr_length,
    input  logic [7:0]                 apple,
    output logic                       hit_self,
    output logic                       hit_apple
);

    logic [MAX_LENGTH-1:0] match;

    // Slot 0 is the current head and the tail slot
    // is vacated by the same move, so both are skipped.
    always_comb begin
        match = '0;
        for (int i = 1; i < MAX_LENGTH; i++) begin
            match[i] = (i < int'(curr_length)) && (body[i] == head);
        end
    end

    assign hit_self  = |match;
    assign hit_apple = (head == apple);   // Proposed head lands on the apple.

endmodule

/* direction_filter.sv */
`timescale 1ns/1ps

module direction_filter (
    input  logic                  clk,
    input  logic                  nrst,
    input  logic                  sync,
    input  logic                  pulse,
    input  snake_pkg::direction_t btn,
    input  logic                  btn_valid,
    output snake_pkg::direction_t direction
);

    snake_pkg::direction_t req_dir;     // Used for the next move.
    snake_pkg::direction_t last_dir;    // Direction of the last move.
    snake_pkg::direction_t ref_dir;
    logic                  reversal;

    // A move on this edge commits req_dir, so check against that one.
    assign ref_dir  = pulse ? req_dir : last_dir;
    assign reversal = (btn[1] == ref_dir[1]) && (btn[0] != ref_dir[0]);

    always_ff @(posedge clk or negedge nrst) begin
        if (!nrst) begin
            req_dir  <= snake_pkg::RIGHT;
            last_dir <= snake_pkg::RIGHT;
        end else if (sync) begin
            req_dir  <= snake_pkg::RIGHT;
            last_dir <= snake_pkg::RIGHT;
        end else begin
            if (pulse) begin
                last_dir <= req_dir;
            end
            if (btn_valid && !reversal) begin
                req_dir <= btn;
            end
        end
    end

    assign direction = req_dir;

endmodule

/* snake.f */
+incdir+.
snake_pkg.sv
snake_ctrl.sv
direction_filter.sv
update_body.sv
collision_check.sv
apple_gen.sv
snake_core.sv
snake_clk_gen.sv
snake_assert.sv
snake_tb.sv

/* snake_assert.sv */
`timescale 1ns/1ps
`include "snake_defines.svh"

module snake_assert (
    input logic                     clk,
    input logic                     nrst,
    input logic                     sync,
    input logic                     pulse,
    input logic [6:0]               curr_length,
    input snake_pkg::snake_status_t status
);

    int error_count = 0;    // Read by the testbench at the end.

    pulse_sync_excl: assert property (@(posedge clk) disable iff (!nrst) !(pulse && sync))
        else begin
            $error("pulse and sync high in the same cycle");
            error_count++;
        end

    run_after_sync: assert property (@(posedge clk) disable iff (!nrst)
        sync |=> status.state == snake_pkg::RUN)
        else begin
            $error("state is not RUN after a restart");
            error_count++;
        end

    length_limit: assert property (@(posedge clk) disable iff (!nrst)
        curr_length <= 7'(`SNAKE_MAX_LENGTH - 1))
        else begin
            $error("length above its maximum");
            error_count++;
        end

endmodule

bind snake_core snake_assert u_assert (
    .clk         (clk),
    .nrst        (nrst),
    .sync        (sync),
    .pulse       (pulse),
    .curr_length (curr_length),
    .status      (status)
);

/* snake_clk_gen.sv */
`timescale 1ns/1ps

module snake_clk_gen #(
    parameter int PERIOD_NS    = 100,
    parameter int RESET_CYCLES = 2
) (
    output logic clk,
    output logic nrst
);

    initial begin
        clk = 1'b0;
        forever #(PERIOD_NS / 2) clk = ~clk;
    end

    initial begin
        nrst = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        #10 nrst = 1'b1;    // Released off the edge.
    end

endmodule

/* snake_core.sv */
`timescale 1ns/1ps
`include "snake_defines.svh"

module snake_core (
    input  logic                              clk,
    input  logic                              nrst,
    input  logic                              start,
    input  logic                              tick,
    input  snake_pkg::direction_t             btn,
    input  logic                              btn_valid,
    output logic [`SNAKE_MAX_LENGTH-1:0][7:0] body,
    output logic [7:0]                        head,
    output logic [7:0]                        apple,
    output snake_pkg::snake_status_t          status
);

    logic                  sync;
    logic                  pulse;
    logic                  eat;
    logic                  hit_self;
    logic                  hit_apple;
    logic [6:0]            curr_length;
    snake_pkg::direction_t direction;

    // ======================================================================
    // Control
    // ======================================================================

    snake_ctrl u_ctrl (
        .clk         (clk),
        .nrst        (nrst),
        .start       (start),
        .tick        (tick),
        .hit_self    (hit_self),
        .hit_apple   (hit_apple),
        .sync        (sync),
        .pulse       (pulse),
        .eat         (eat),
        .curr_length (curr_length),
        .status      (status)
    );

    // ======================================================================
    // Datapath
    // ======================================================================

    direction_filter u_dir (
        .clk       (clk),
        .nrst      (nrst),
        .sync      (sync),
        .pulse     (pulse),
        .btn       (btn),
        .btn_valid (btn_valid),
        .direction (direction)
    );

    update_body #(.MAX_LENGTH(`SNAKE_MAX_LENGTH)) u_body (
        .clk         (clk),
        .nrst        (nrst),
        .pulse       (pulse),
        .sync        (sync),
        .direction   (direction),
        .curr_length (curr_length),
        .body        (body),
        .head        (head)
    );

    collision_check #(.MAX_LENGTH(`SNAKE_MAX_LENGTH)) u_collide (
        .head        (head),
        .body        (body),
        .curr_length (curr_length),
        .apple       (apple),
        .hit_self    (hit_self),
        .hit_apple   (hit_apple)
    );

    apple_gen u_apple (
        .clk   (clk),
        .nrst  (nrst),
        .sync  (sync),
        .eat   (eat),
        .apple (apple)
    );

endmodule

/* snake_ctrl.sv */
`timescale 1ns/1ps
`include "snake_defines.svh"

module snake_ctrl (
    input  logic                     clk,
    input  logic                     nrst,
    input  logic                     start,
    input  logic                     tick,
    input  logic                     hit_self,
    input  logic                     hit_apple,
    output logic                     sync,
    output logic                     pulse,
    output logic                     eat,
    output logic [6:0]               curr_length,
    output snake_pkg::snake_status_t status
);

    localparam logic [6:0] LEN_MAX = 7'(`SNAKE_MAX_LENGTH - 1);

    snake_pkg::game_state_t state;
    snake_pkg::game_state_t state_next;
    logic [6:0]             score;
    logic                   running;

    assign running = (state == snake_pkg::RUN);

    assign sync  = start;
    assign pulse = tick & running & ~hit_self;
    assign eat   = pulse & hit_apple;

    // ======================================================================
    // State machine
    // ======================================================================

    always_comb begin
        state_next = state;
        if (start) begin
            state_next = snake_pkg::RUN;
        end else if (running && tick && hit_self) begin
            state_next = snake_pkg::OVER;      // Head ran into the body.
        end
    end

    always_ff @(posedge clk or negedge nrst) begin
        if (!nrst) begin
            state <= snake_pkg::IDLE;
        end else begin
            state <= state_next;
        end
    end

    // ======================================================================
    // Length and score
    // ======================================================================

    always_ff @(posedge clk or negedge nrst) begin
        if (!nrst) begin
            curr_length <= `SNAKE_START_LEN;
            score       <= '0;
        end else if (sync) begin
            curr_length <= `SNAKE_START_LEN;
            score       <= '0;
        end else if (eat) begin
            if (curr_length < LEN_MAX) begin
                curr_length <= curr_length + 7'd1;
            end
            if (score != 7'h7F) begin
                score <= score + 7'd1;
            end
        end
    end

    assign status = '{state: state, score: score, length: curr_length};

endmodule

/* snake_defines.svh */
`ifndef SNAKE_DEFINES_SVH
`define SNAKE_DEFINES_SVH

// ======================================================================
// Field and body
// ======================================================================
// Positions are one byte, x in the upper nibble and y in the lower.

`define SNAKE_MAX_LENGTH 50      // Body slots.
`define SNAKE_START_POS  8'h44   // Head after restart.
`define SNAKE_START_LEN  7'd2    // Tail index after restart.

// ======================================================================
// Apple generator
// ======================================================================

`define SNAKE_LFSR_SEED  8'hA5
`define SNAKE_LFSR_TAPS  8'hB8   // Galois feedback mask.

`endif

/* snake_pkg.sv */
package snake_pkg;

    // ======================================================================
    // Movement
    // ======================================================================

    // Opposite pairs differ only in bit 0.
    typedef enum logic [1:0] {
        LEFT  = 2'd0,
        RIGHT = 2'd1,
        UP    = 2'd2,
        DOWN  = 2'd3
    } direction_t;

    // ======================================================================
    // Game control
    // ======================================================================

    typedef enum logic [1:0] {
        IDLE = 2'd0,
        RUN  = 2'd1,
        OVER = 2'd2
    } game_state_t;

    typedef struct packed {
        game_state_t state;
        logic [6:0]  score;    // Apples eaten.
        logic [6:0]  length;   // Tail index.
    } snake_status_t;

endpackage

/* snake_tb.sv */
`timescale 1ns/1ps
`include "snake_defines.svh"

module snake_tb;

    localparam int MAX_LEN = `SNAKE_MAX_LENGTH;

    typedef logic [MAX_LEN-1:0][7:0] body_t;

    typedef struct packed {
        logic                   start;
        snake_pkg::direction_t  btn;
        logic                   btn_valid;
        logic [7:0]             ticks;
        logic [7:0]             exp_head;
        logic [6:0]             exp_score;
        snake_pkg::game_state_t exp_state;
        logic [7:0]             exp_apple;
        logic [6:0]             exp_length;
        body_t                  exp_body;
    } step_t;

    logic                     clk;
    logic                     nrst;
    logic                     start;
    logic                     tick;
    snake_pkg::direction_t    btn;
    logic                     btn_valid;
    body_t                    body;
    logic [7:0]               head;
    logic [7:0]               apple;
    snake_pkg::snake_status_t status;

    step_t       steps[$];
    int unsigned cycle_count = 0;
    int unsigned cycle_limit = 0;

    // Reference model.
    body_t                  m_body;
    logic [6:0]             m_len;
    logic [6:0]             m_score;
    snake_pkg::game_state_t m_state;
    snake_pkg::direction_t  m_req;
    snake_pkg::direction_t  m_last;
    logic [7:0]             m_apple;

    snake_clk_gen u_clk_gen (.clk(clk), .nrst(nrst));

    snake_core dut (
        .clk       (clk),
        .nrst      (nrst),
        .start     (start),
        .tick      (tick),
        .btn       (btn),
        .btn_valid (btn_valid),
        .body      (body),
        .head      (head),
        .apple     (apple),
        .status    (status)
    );

    // ======================================================================
    // Reference model
    // ======================================================================

    function automatic logic [7:0] move_pos(input logic [7:0] pos,
                                            input snake_pkg::direction_t dir);
        logic [3:0] x;
        logic [3:0] y;
        x = pos[7:4];
        y = pos[3:0];
        case (dir)
            snake_pkg::LEFT:  x = x - 4'd1;
            snake_pkg::RIGHT: x = x + 4'd1;
            snake_pkg::UP:    y = y - 4'd1;
            default:          y = y + 4'd1;
        endcase
        return {x, y};
    endfunction

    function automatic logic is_reverse(input snake_pkg::direction_t a,
                                        input snake_pkg::direction_t b);
        case (a)
            snake_pkg::LEFT:  return b == snake_pkg::RIGHT;
            snake_pkg::RIGHT: return b == snake_pkg::LEFT;
            snake_pkg::UP:    return b == snake_pkg::DOWN;
            default:          return b == snake_pkg::UP;
        endcase
    endfunction

    function automatic logic [7:0] lfsr_next(input logic [7:0] v);
        logic [7:0] shifted;
        shifted = v >> 1;
        if (v[0]) begin
            shifted = shifted ^ `SNAKE_LFSR_TAPS;
        end
        return shifted;
    endfunction

    function automatic void model_restart(input snake_pkg::game_state_t st);
        m_body = '0;
        for (int i = 0; i <= `SNAKE_START_LEN; i++) begin
            m_body[i] = 8'(`SNAKE_START_POS - 16 * i);    // Trails to the left.
        end
        m_len   = `SNAKE_START_LEN;
        m_score = '0;
        m_state = st;
        m_req   = snake_pkg::RIGHT;
        m_last  = snake_pkg::RIGHT;
        m_apple = `SNAKE_LFSR_SEED;
    endfunction

    function automatic void model_tick();
        logic [7:0] nh;
        logic       self_hit;
        if (m_state != snake_pkg::RUN) begin
            return;
        end
        nh = move_pos(m_body[0], m_req);
        self_hit = 1'b0;
        for (int i = 1; i < m_len; i++) begin
            if (m_body[i] == nh) begin
                self_hit = 1'b1;
            end
        end
        if (self_hit) begin
            m_state = snake_pkg::OVER;
            return;
        end
        for (int i = MAX_LEN - 1; i >= 1; i--) begin
            m_body[i] = (i <= m_len) ? m_body[i-1] : 8'h00;
        end
        m_body[0] = nh;
        m_last    = m_req;
        if (nh == m_apple) begin
            if (m_len < MAX_LEN - 1) begin
                m_len = m_len + 7'd1;
            end
            if (m_score != 7'h7F) begin
                m_score = m_score + 7'd1;
            end
            m_apple = lfsr_next(m_apple);
        end
    endfunction

    function automatic void model_step(input step_t s);
        if (s.start) begin
            model_restart(snake_pkg::RUN);
        end else if (s.btn_valid && !is_reverse(s.btn, m_last)) begin
            m_req = s.btn;
        end
        for (int t = 0; t < s.ticks; t++) begin
            model_tick();
        end
    endfunction

    // ======================================================================
    // Stimulus table
    // ======================================================================

    function automatic void add_step(input logic st, input snake_pkg::direction_t b,
                                     input logic bv, input int n);
        step_t s;
        s           = '0;
        s.start     = st;
        s.btn       = b;
        s.btn_valid = bv;
        s.ticks     = 8'(n);
        steps.push_back(s);
    endfunction

    function automatic void build_table();
        add_step(1'b0, snake_pkg::RIGHT, 1'b0, 3);   // Ticks in IDLE.
        add_step(1'b1, snake_pkg::RIGHT, 1'b0, 0);
        add_step(1'b0, snake_pkg::RIGHT, 1'b0, 6);
        add_step(1'b0, snake_pkg::DOWN,  1'b1, 1);   // Onto the first apple.
        add_step(1'b0, snake_pkg::UP,    1'b1, 2);   // Reversal.
        add_step(1'b0, snake_pkg::DOWN,  1'b0, 2);
        add_step(1'b0, snake_pkg::RIGHT, 1'b1, 4);
        add_step(1'b0, snake_pkg::DOWN,  1'b1, 1);   // Onto the second apple.
        add_step(1'b0, snake_pkg::DOWN,  1'b0, 6);   // Bottom edge.
        add_step(1'b0, snake_pkg::RIGHT, 1'b1, 3);   // Right edge.
        add_step(1'b0, snake_pkg::UP,    1'b1, 2);   // Top edge.
        add_step(1'b0, snake_pkg::LEFT,  1'b1, 3);   // Left edge.
        add_step(1'b0, snake_pkg::DOWN,  1'b1, 1);
        add_step(1'b0, snake_pkg::RIGHT, 1'b1, 1);
        add_step(1'b0, snake_pkg::UP,    1'b1, 1);   // Into the body.
        add_step(1'b0, snake_pkg::DOWN,  1'b1, 3);
        add_step(1'b1, snake_pkg::RIGHT, 1'b0, 0);
        for (int r = 0; r < 24; r++) begin
            add_step(1'b0, snake_pkg::direction_t'($urandom_range(3, 0)),
                     1'($urandom_range(1, 0)), int'($urandom_range(4, 1)));
        end
    endfunction

    function automatic void fill_expected();
        step_t s;
        model_restart(snake_pkg::IDLE);
        foreach (steps[i]) begin
            s = steps[i];
            model_step(s);
            s.exp_head   = move_pos(m_body[0], m_req);
            s.exp_score  = m_score;
            s.exp_state  = m_state;
            s.exp_apple  = m_apple;
            s.exp_length = m_len;
            s.exp_body   = m_body;
            steps[i]     = s;
        end
    endfunction

    // ======================================================================
    // Checks
    // ======================================================================

    task automatic stop_run();
        $display("FAIL: see errors above");
        $fatal(1, "Run stopped.");
    endtask

    task automatic check_pos(input string name, input logic [7:0] got, input logic [7:0] exp);
        if (got !== exp) begin
            $display("FAIL %s: got 0x%02h expected 0x%02h", name, got, exp);
            stop_run();
        end
    endtask

    task automatic check_status(input string name, input snake_pkg::snake_status_t got,
                                input snake_pkg::snake_status_t exp);
        if (got !== exp) begin
            $display("FAIL %s: got 0x%04h expected 0x%04h", name, got, exp);
            stop_run();
        end
    endtask

    task automatic check_state(input string name, input snake_pkg::game_state_t got,
                               input snake_pkg::game_state_t exp);
        if (got !== exp) begin
            $display("FAIL %s: got 0x%01h expected 0x%01h", name, got, exp);
            stop_run();
        end
    endtask

    task automatic check_step(input int r, input step_t s);
        snake_pkg::snake_status_t exp_status;
        exp_status = '{state: s.exp_state, score: s.exp_score, length: s.exp_length};
        check_state($sformatf("step %0d status.state", r), status.state, s.exp_state);
        check_status($sformatf("step %0d status", r), status, exp_status);
        check_pos($sformatf("step %0d head", r), head, s.exp_head);
        check_pos($sformatf("step %0d apple", r), apple, s.exp_apple);
        for (int i = 0; i < MAX_LEN; i++) begin
            check_pos($sformatf("step %0d body[%0d]", r, i), body[i], s.exp_body[i]);
        end
    endtask

    // ======================================================================
    // Drive and run
    // ======================================================================

    task automatic next_cycle();
        @(posedge clk);
        #10;
    endtask

    task automatic apply_step(input step_t s);
        start     = s.start;
        btn       = s.btn;
        btn_valid = s.btn_valid;
        next_cycle();
        start     = 1'b0;
        btn_valid = 1'b0;
        for (int t = 0; t < s.ticks; t++) begin
            tick = 1'b1;
            next_cycle();
            tick = 1'b0;
            next_cycle();
        end
    endtask

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_limit != 0 && cycle_count >= cycle_limit) begin
            $display("Timeout: the tests did not finish within %0d cycles", cycle_limit);
            stop_run();
        end
    end

    initial begin
        int unsigned total_ticks;
        start     = 1'b0;
        tick      = 1'b0;
        btn       = snake_pkg::RIGHT;
        btn_valid = 1'b0;
        void'($urandom(52793));
        build_table();
        fill_expected();
        total_ticks = 0;
        foreach (steps[i]) begin
            total_ticks += steps[i].ticks;
        end
        cycle_limit = total_ticks * 4 + 100;
        wait (nrst === 1'b1);
        foreach (steps[i]) begin
            apply_step(steps[i]);
            check_step(i, steps[i]);
        end
        if (dut.u_assert.error_count == 0) begin
            $display("PASS: all tests");
            $finish;
        end else begin
            stop_run();
        end
    end

endmodule

/* update_body.sv */
`timescale 1ns/1ps
`include "snake_defines.svh"

module update_body #(
    parameter int MAX_LENGTH = `SNAKE_MAX_LENGTH
) (
    input  logic                       clk,
    input  logic                       nrst,
    input  logic                       pulse,
    input  logic                       sync,
    input  snake_pkg::direction_t      direction,
    input  logic [6:0]                 curr_length,
    output logic [MAX_LENGTH-1:0][7:0] body,
    output logic [7:0]                 head
);

    localparam logic [7:0] START_POS = `SNAKE_START_POS;
    localparam int         START_LEN = `SNAKE_START_LEN;

    // Start body trails to the left of the head.
    function automatic logic [MAX_LENGTH-1:0][7:0] make_start_body();
        logic [MAX_LENGTH-1:0][7:0] b;
        b = '0;
        for (int i = 0; i <= START_LEN; i++) begin
            b[i] = {START_POS[7:4] - 4'(i), START_POS[3:0]};
        end
        return b;
    endfunction

    localparam logic [MAX_LENGTH-1:0][7:0] START_BODY = make_start_body();

    logic [MAX_LENGTH-1:0][7:0] current;
    logic [MAX_LENGTH-1:0][7:0] next;
    logic [3:0]                 head_x;
    logic [3:0]                 head_y;

    // ======================================================================
    // Next head
    // ======================================================================

    // Nibble arithmetic wraps at the field edges.
    always_comb begin
        head_x = current[0][7:4];
        head_y = current[0][3:0];
        case (direction)
            snake_pkg::LEFT:  head_x = current[0][7:4] - 4'd1;
            snake_pkg::RIGHT: head_x = current[0][7:4] + 4'd1;
            snake_pkg::UP:    head_y = current[0][3:0] - 4'd1;
            snake_pkg::DOWN:  head_y = current[0][3:0] + 4'd1;
            default: begin
                head_x = current[0][7:4];
                head_y = current[0][3:0];
            end
        endcase
    end

    // ======================================================================
    // Body shift register
    // ======================================================================

    always_comb begin
        next = current;
        if (sync) begin
            next = START_BODY;
        end else if (pulse) begin
            next[0] = {head_x, head_y};
            for (int i = 1; i < MAX_LENGTH; i++) begin
                if (i <= int'(curr_length)) begin
                    next[i] = current[i-1];
                end else begin
                    next[i] = 8'h00;      // Unused slot.
                end
            end
        end
    end

    always_ff @(posedge clk or negedge nrst) begin
        if (!nrst) begin
            current <= START_BODY;
        end else begin
            current <= next;
        end
    end

    assign body = current;
    assign head = {head_x, head_y};

endmodule
